// ==== common/uart_echo_pkg.sv ====
// Shared types and constants for the UART framing echo.
// Every block refers to these by scoped name, uart_echo_pkg::name.

package uart_echo_pkg;

	// one serial data byte
	typedef logic [7:0] byte_t;

	// byte count or buffer index
	typedef logic [7:0] cnt_t;

	// frame marker, sent twice before and twice after the payload
	localparam byte_t FRAME_MARK = 8'h26; // "&"

	// buffer size in bytes, two head and two tail markers included
	localparam int BUF_DEPTH = 64;

	// frame controller sequencing
	typedef enum logic [1:0] {
		IDLE,    // waiting for the first byte
		COLLECT, // buffering bytes, gap timer running
		SEND,    // walking the buffer out to the transmitter
		CLOSE    // frame done, length published
	} frame_state_t;

endpackage

// ==== uart_rx/uart_rx.sv ====
// Serial receiver, 8 data bits LSB first, one stop bit.
// rx_vld pulses for one clock at the stop bit center; a low stop bit drops the byte.

`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 rx_pin,
	output uart_echo_pkg::byte_t rx_data,
	output logic                 rx_vld
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t            state;
	logic                 rx_meta;
	logic                 rx_sync;
	logic                 rx_prev;
	logic [CNT_W-1:0]     clk_cnt;
	logic [2:0]           bit_idx;
	uart_echo_pkg::byte_t shift_reg;

	// two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_pin;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (rx_prev && !rx_sync)
						state <= RX_START; // falling edge
				end
				RX_START: begin
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						state   <= rx_sync ? RX_IDLE : RX_DATA; // glitch, back to idle
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				RX_DATA: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				RX_STOP: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						rx_vld  <= rx_sync; // low stop bit is a framing error
						state   <= RX_IDLE;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data path, bits shifted in from the top
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && clk_cnt == BIT_LAST)
			shift_reg <= {rx_sync, shift_reg[7:1]};
		if (state == RX_STOP && clk_cnt == BIT_LAST && rx_sync)
			rx_data <= shift_reg; // held until the next good byte
	end

endmodule

// ==== uart_tx/uart_tx.sv ====
// Serial transmitter, start bit, 8 data bits LSB first, TX_STOP_BITS stop bits.
// A tx_req while idle starts a byte; tx_done marks its last clock.

`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 434,
	parameter int TX_STOP_BITS = 2
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 tx_req,
	input  uart_echo_pkg::byte_t tx_data,
	output logic                 tx_pin,
	output logic                 tx_done
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [3:0]       STOP_LAST = 4'(TX_STOP_BITS - 1);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t            state;
	logic [CNT_W-1:0]     clk_cnt;
	logic [3:0]           bit_idx; // data bit, then stop bit index
	uart_echo_pkg::byte_t shift_reg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx_pin  <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					tx_pin  <= 1'b1;
					if (tx_req) begin
						tx_pin <= 1'b0; // start bit from the next clock
						state  <= TX_START;
					end
				end
				TX_START: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						tx_pin  <= shift_reg[0];
						state   <= TX_DATA;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				TX_DATA: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						if (bit_idx == 4'd7) begin
							bit_idx <= '0;
							tx_pin  <= 1'b1;
							state   <= TX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx_pin  <= shift_reg[1];
						end
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				TX_STOP: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == STOP_LAST)
							state <= TX_IDLE;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// byte latch and shift, bit 0 is always the one on the line
	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && tx_req)
			shift_reg <= tx_data;
		else if (state == TX_DATA && clk_cnt == BIT_LAST)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

	assign tx_done = (state == TX_STOP) && (clk_cnt == BIT_LAST) && (bit_idx == STOP_LAST);

endmodule

// ==== frame_ctrl/uart_frame_ctrl.sv ====
// Frame buffer and echo sequencer.
// Bytes are collected behind two "&" markers until the line has been quiet for
// IDLE_CLKS clocks, then the frame plus two trailing markers goes out byte by byte.

`timescale 1ns/1ps

module uart_frame_ctrl #(
	parameter int IDLE_CLKS = 50_000
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  uart_echo_pkg::byte_t rx_data,
	input  logic                 rx_vld,
	input  logic                 tx_done,
	output uart_echo_pkg::byte_t tx_data,
	output logic                 tx_req,
	output uart_echo_pkg::cnt_t  frame_len
);

	localparam int IDX_W = $clog2(uart_echo_pkg::BUF_DEPTH);
	localparam int GAP_W = $clog2(IDLE_CLKS);
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(IDLE_CLKS - 1);
	// room left after the four markers
	localparam uart_echo_pkg::cnt_t PAY_MAX = uart_echo_pkg::cnt_t'(uart_echo_pkg::BUF_DEPTH - 4);

	uart_echo_pkg::frame_state_t state;
	uart_echo_pkg::byte_t        frame_buf [uart_echo_pkg::BUF_DEPTH];
	uart_echo_pkg::cnt_t         pay_cnt;  // payload bytes accepted
	uart_echo_pkg::cnt_t         send_idx; // next buffer entry to send
	logic [GAP_W-1:0]            gap_cnt;
	logic [IDX_W-1:0]            wr_idx;
	logic [IDX_W-1:0]            rd_idx;
	logic                        byte_acc;
	logic                        gap_done;
	logic                        send_end;

	assign wr_idx = IDX_W'(pay_cnt + uart_echo_pkg::cnt_t'(2));
	assign rd_idx = IDX_W'(send_idx);

	// new bytes only before the echo starts and while there is room
	assign byte_acc = rx_vld && (pay_cnt < PAY_MAX) &&
		(state == uart_echo_pkg::IDLE || state == uart_echo_pkg::COLLECT);
	// a byte in the same cycle restarts the gap instead
	assign gap_done = (state == uart_echo_pkg::COLLECT) && (gap_cnt == GAP_LAST) && !rx_vld;
	// last trailing marker finished
	assign send_end = (state == uart_echo_pkg::SEND) && tx_done &&
		(send_idx == pay_cnt + uart_echo_pkg::cnt_t'(4));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			state <= uart_echo_pkg::IDLE;
		else begin
			case (state)
				uart_echo_pkg::IDLE:
					if (rx_vld)
						state <= uart_echo_pkg::COLLECT;
				uart_echo_pkg::COLLECT:
					if (gap_done)
						state <= uart_echo_pkg::SEND;
				uart_echo_pkg::SEND:
					if (send_end)
						state <= uart_echo_pkg::CLOSE;
				uart_echo_pkg::CLOSE:
					state <= uart_echo_pkg::IDLE;
				default:
					state <= uart_echo_pkg::IDLE;
			endcase
		end
	end

	// quiet-line timer
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			gap_cnt <= '0;
		else if (state != uart_echo_pkg::COLLECT || rx_vld || gap_done)
			gap_cnt <= '0;
		else
			gap_cnt <= gap_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pay_cnt   <= '0;
			frame_len <= '0;
		end else if (byte_acc)
			pay_cnt <= pay_cnt + 1'b1;
		else if (state == uart_echo_pkg::CLOSE) begin
			frame_len <= pay_cnt; // publish, then start over
			pay_cnt   <= '0;
		end
	end

	// head markers sit at 0 and 1 and are never overwritten
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame_buf[0] <= uart_echo_pkg::FRAME_MARK;
			frame_buf[1] <= uart_echo_pkg::FRAME_MARK;
		end else if (byte_acc)
			frame_buf[wr_idx] <= rx_data;
		else if (gap_done) begin
			frame_buf[wr_idx]            <= uart_echo_pkg::FRAME_MARK;
			frame_buf[wr_idx + IDX_W'(1)] <= uart_echo_pkg::FRAME_MARK;
		end
	end

	// one tx_req per byte, the next one a clock after each tx_done
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_req   <= 1'b0;
			send_idx <= '0;
		end else begin
			tx_req <= 1'b0;
			if (gap_done) begin
				tx_req   <= 1'b1;
				send_idx <= uart_echo_pkg::cnt_t'(1);
			end else if (state == uart_echo_pkg::SEND && tx_done && !send_end) begin
				tx_req   <= 1'b1;
				send_idx <= send_idx + 1'b1;
			end
		end
	end

	// byte handed to the transmitter, stable while tx_req is high
	always_ff @(posedge sys_clk) begin
		if (gap_done)
			tx_data <= frame_buf[0];
		else if (state == uart_echo_pkg::SEND && tx_done && !send_end)
			tx_data <= frame_buf[rd_idx];
	end

endmodule

// ==== verilog/uart_echo_top.sv ====
// UART framing echo top level.
// Received bytes are framed by the controller and sent back with "&&" on both sides.

`timescale 1ns/1ps

module uart_echo_top #(
	parameter int CLKS_PER_BIT = 434,
	parameter int TX_STOP_BITS = 2,
	parameter int IDLE_CLKS    = 50_000
) (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                rx_pin,
	output logic                tx_pin,
	output uart_echo_pkg::cnt_t frame_len
);

	uart_echo_pkg::byte_t rx_data;
	logic                 rx_vld;
	uart_echo_pkg::byte_t tx_data;
	logic                 tx_req;
	logic                 tx_done;

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_pin    (rx_pin),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld)
	);

	uart_frame_ctrl #(
		.IDLE_CLKS (IDLE_CLKS)
	) u_frame_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.tx_done   (tx_done),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.frame_len (frame_len)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.TX_STOP_BITS (TX_STOP_BITS)
	) u_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx_data   (tx_data),
		.tx_pin    (tx_pin),
		.tx_done   (tx_done)
	);

endmodule

// ==== dv/uart_echo_sva.sv ====
// Assertions on the echo top level, bound into uart_echo_top.
// Checks the idle line, transmit requests and frame_len updates.

`timescale 1ns/1ps

module uart_echo_sva (
	input logic                        sys_clk,
	input logic                        sys_rst_n,
	input logic                        tx_pin,
	input logic                        tx_req,
	input uart_echo_pkg::frame_state_t fc_state,
	input uart_echo_pkg::cnt_t         frame_len
);

	logic seen_req; // first byte requested since reset

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			seen_req <= 1'b0;
		else if (tx_req)
			seen_req <= 1'b1;
	end

	idle_line_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!seen_req |-> tx_pin)
		else $error("tx_pin left idle before the first transmit request");

	no_req_in_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		fc_state == uart_echo_pkg::IDLE |-> !tx_req)
		else $error("tx_req high while the frame controller is in IDLE");

	len_only_in_close: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		frame_len != $past(frame_len) |-> $past(fc_state) == uart_echo_pkg::CLOSE)
		else $error("frame_len changed outside CLOSE");

endmodule

bind uart_echo_top uart_echo_sva sva0 (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.tx_pin    (tx_pin),
	.tx_req    (tx_req),
	.fc_state  (u_frame_ctrl.state),
	.frame_len (frame_len)
);

// ==== dv/uart_echo_tb.sv ====
// Directed testbench for the UART framing echo.
// Drives bytes into rx_pin, decodes tx_pin and checks the "&&" framed echo and frame_len.

`timescale 1ns/1ps

module uart_echo_tb;

	localparam int CLKS       = 8;
	localparam int STOPS      = 2;
	localparam int IDLE       = 400;
	localparam int PAY_LIMIT  = uart_echo_pkg::BUF_DEPTH - 4; // four markers take the rest
	localparam int MAX_CYCLES = 200_000; // worst case of all tests plus margin

	logic                sys_clk = 1'b0;
	logic                sys_rst_n;
	logic                rx_pin;
	logic                tx_pin;
	uart_echo_pkg::cnt_t frame_len;

	uart_echo_pkg::byte_t mon_q[$];  // bytes decoded from tx_pin
	int                   stop_q[$]; // stop bits seen per byte
	uart_echo_pkg::byte_t pay_q[$];  // payload the DUT should accept
	integer               seed = 69129;
	int                   cycle_cnt = 0;
	string                cur_test = "none";

	uart_echo_top #(
		.CLKS_PER_BIT (CLKS),
		.TX_STOP_BITS (STOPS),
		.IDLE_CLKS    (IDLE)
	) dut0 (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_pin    (rx_pin),
		.tx_pin    (tx_pin),
		.frame_len (frame_len)
	);

	always #2 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Error: %s did not finish within %0d cycles", cur_test, MAX_CYCLES);
			$display("** FAIL **");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic check(input string what, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		if (exp_val !== act_val) begin
			$display("** Error %s: %s expected %0h, actual %0h", cur_test, what, exp_val, act_val);
			$display("** FAIL **");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// one byte on rx_pin, 1 stop bit, optionally held low
	task automatic send_byte(input uart_echo_pkg::byte_t b, input logic bad_stop);
		int i;
		@(posedge sys_clk);
		rx_pin <= 1'b0;
		repeat (CLKS) @(posedge sys_clk);
		for (i = 0; i < 8; i++) begin
			rx_pin <= b[i];
			repeat (CLKS) @(posedge sys_clk);
		end
		rx_pin <= ~bad_stop;
		repeat (CLKS) @(posedge sys_clk);
		rx_pin <= 1'b1;
	endtask

	// samples at bit centers, counts up to two stop bits
	task automatic monitor_line();
		uart_echo_pkg::byte_t b;
		int                   stops;
		int                   i;
		forever begin
			@(posedge sys_clk);
			if (tx_pin == 1'b0) begin
				repeat (CLKS / 2 - 1) @(posedge sys_clk);
				check("start bit at center", 32'd0, 32'(tx_pin));
				for (i = 0; i < 8; i++) begin
					repeat (CLKS) @(posedge sys_clk);
					b[i] = tx_pin;
				end
				stops = 0;
				repeat (CLKS) @(posedge sys_clk);
				if (tx_pin) begin
					stops = 1;
					repeat (CLKS) @(posedge sys_clk);
					if (tx_pin)
						stops = 2;
				end
				mon_q.push_back(b);
				stop_q.push_back(stops);
			end
		end
	endtask

	// expected echo is "&&" + accepted payload + "&&"
	task automatic check_echo(input int exp_len);
		uart_echo_pkg::byte_t exp_q[$];
		int                   i;
		exp_q.push_back(uart_echo_pkg::FRAME_MARK);
		exp_q.push_back(uart_echo_pkg::FRAME_MARK);
		for (i = 0; i < pay_q.size(); i++)
			exp_q.push_back(pay_q[i]);
		exp_q.push_back(uart_echo_pkg::FRAME_MARK);
		exp_q.push_back(uart_echo_pkg::FRAME_MARK);
		while (mon_q.size() < exp_q.size())
			@(posedge sys_clk);
		// long enough for a stray extra byte to be decoded and for frame_len to settle
		repeat ((2 + 8 + STOPS) * CLKS) @(posedge sys_clk);
		check("echo byte count", 32'(exp_q.size()), 32'(mon_q.size()));
		for (i = 0; i < exp_q.size(); i++) begin
			check($sformatf("echo byte %0d", i), 32'(exp_q[i]), 32'(mon_q[i]));
			check($sformatf("stop bits of byte %0d", i), 32'(STOPS), 32'(stop_q[i]));
		end
		check("frame_len", 32'(exp_len), 32'(frame_len));
		mon_q.delete();
		stop_q.delete();
		pay_q.delete();
	endtask

	task automatic test_reset_idle();
		int i;
		cur_test = "test_reset_idle";
		for (i = 0; i < 1000; i++) begin
			@(posedge sys_clk);
			check("tx_pin idle", 32'd1, 32'(tx_pin));
		end
		check("frame_len", 32'd0, 32'(frame_len));
	endtask

	task automatic test_single_byte();
		cur_test = "test_single_byte";
		pay_q.push_back(8'h41); // "A"
		send_byte(8'h41, 1'b0);
		check_echo(1);
	endtask

	task automatic test_random_string();
		uart_echo_pkg::byte_t b;
		int                   i;
		int                   gap;
		cur_test = "test_random_string";
		for (i = 0; i < 12; i++) begin
			b = uart_echo_pkg::byte_t'($random(seed));
			pay_q.push_back(b);
			send_byte(b, 1'b0);
			gap = $random(seed) & 63; // well below IDLE
			repeat (gap) @(posedge sys_clk);
		end
		check_echo(12);
	endtask

	task automatic test_busy_drop();
		cur_test = "test_busy_drop";
		pay_q.push_back(8'h31);
		pay_q.push_back(8'h32);
		pay_q.push_back(8'h33);
		send_byte(8'h31, 1'b0);
		send_byte(8'h32, 1'b0);
		send_byte(8'h33, 1'b0);
		while (mon_q.size() < 1)
			@(posedge sys_clk);
		send_byte(8'h58, 1'b0); // arrive mid echo, dropped
		send_byte(8'h59, 1'b0);
		check_echo(3);
		pay_q.push_back(8'h6b);
		pay_q.push_back(8'h6c);
		send_byte(8'h6b, 1'b0);
		send_byte(8'h6c, 1'b0);
		check_echo(2);
	endtask

	task automatic test_overflow();
		uart_echo_pkg::byte_t b;
		int                   i;
		cur_test = "test_overflow";
		for (i = 0; i < PAY_LIMIT + 2; i++) begin
			b = uart_echo_pkg::byte_t'($random(seed));
			if (i < PAY_LIMIT)
				pay_q.push_back(b);
			send_byte(b, 1'b0);
		end
		check_echo(PAY_LIMIT);
	endtask

	task automatic test_framing_error();
		cur_test = "test_framing_error";
		pay_q.push_back(8'h78); // "x"
		pay_q.push_back(8'h79); // "y"
		send_byte(8'h78, 1'b0);
		send_byte(8'ha5, 1'b1);
		repeat (2 * CLKS) @(posedge sys_clk); // line back high before the next start
		send_byte(8'h79, 1'b0);
		check_echo(2);
	endtask

	initial begin
		@(posedge sys_rst_n);
		monitor_line();
	end

	initial begin
		sys_rst_n = 1'b0;
		rx_pin    = 1'b1;
		repeat (8) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		test_reset_idle();
		test_single_byte();
		test_random_string();
		test_busy_drop();
		test_overflow();
		test_framing_error();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== uart_echo_top.f ====
common/uart_echo_pkg.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
frame_ctrl/uart_frame_ctrl.sv
verilog/uart_echo_top.sv
dv/uart_echo_sva.sv
dv/uart_echo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the UART echo testbench with Verilator, runs it and searches the log for a pass.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f uart_echo_top.f \
	--top-module uart_echo_tb -o uart_echo_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/uart_echo_sim > sim.log 2>&1
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" \
	|| { cat sim.log; echo "simulation failed"; exit 1; }
